//--- common/sms_pkg.sv
`default_nettype none

package sms_pkg;

   localparam int ADDR_W    = 16;
   localparam int DATA_W    = 8;
   localparam int BANK_W    = 8;    // one 16 KB page per bank value
   localparam int ROM_A_W   = 22;   // 4 MB cartridge space
   localparam int RAM_A_W   = 13;   // 8 KB work RAM, mirrored
   localparam int NVRAM_A_W = 15;   // two 16 KB backup RAM pages

   // power-on paging, slot n maps page n
   localparam logic [BANK_W-1:0] BANK0_RST = 8'd0;
   localparam logic [BANK_W-1:0] BANK1_RST = 8'd1;
   localparam logic [BANK_W-1:0] BANK2_RST = 8'd2;

   // fffc control, fffd..ffff bank0..bank2
   localparam logic [ADDR_W-1:0] MAP_CTRL_ADDR = 16'hFFFC;

   // codemasters slot writes
   localparam logic [ADDR_W-1:0] CM_SLOT0_ADDR = 16'h0000;
   localparam logic [ADDR_W-1:0] CM_SLOT1_ADDR = 16'h4000;
   localparam logic [ADDR_W-1:0] CM_SLOT2_ADDR = 16'h8000;
   // korean mapper only pages slot 2
   localparam logic [ADDR_W-1:0] KR_SLOT2_ADDR = 16'hA000;

   typedef enum logic {
      IO_SRC_VDP,
      IO_SRC_IOCHIP
   } io_src_e;

   typedef enum logic {
      MAP_SEGA,
      MAP_CODIES     // first kilobyte follows bank0
   } map_mode_e;

endpackage

`default_nettype wire

//--- logic/io_port_decode.sv
`timescale 1ns/1ps
`default_nettype none

module io_port_decode (
   input  wire                        clk_sys,
   input  wire                        RESET_n,
   input  wire [sms_pkg::ADDR_W-1:0]  a,
   input  wire                        iorq_n,
   input  wire                        m1_n,
   input  wire                        rd_n,
   input  wire                        wr_n,
   input  wire                        gg,
   output logic                       vdp_rd_n,
   output logic                       vdp_wr_n,
   output logic                       psg_wr_n,
   output logic                       io_rd_n,
   output logic                       io_wr_n,
   output logic                       ctl_wr_n,
   output sms_pkg::io_src_e           io_src
);

   logic io_cyc;
   logic gg_win;     // handheld ports 00..06
   logic io_chip;
   logic low_port;

   // m1 with iorq is an interrupt ack, not a port access
   assign io_cyc   = !iorq_n && m1_n;
   assign low_port = a[7:6] == 2'b00;
   assign gg_win   = gg && a[7:3] == 5'b00000 && a[2:0] != 3'b111;
   assign io_chip  = a[7:6] == 2'b11 || gg_win;

   assign vdp_rd_n = (io_cyc && (a[7:6] == 2'b01 || a[7:6] == 2'b10)) ? rd_n : 1'b1;
   assign vdp_wr_n = (io_cyc && a[7:6] == 2'b10) ? wr_n : 1'b1;
   assign psg_wr_n = (io_cyc && a[7:6] == 2'b01) ? wr_n : 1'b1;
   assign io_rd_n  = (io_cyc && io_chip) ? rd_n : 1'b1;

   // odd ports reach the io chip, even ports the memory control
   assign io_wr_n  = (io_cyc && low_port && (a[0] || (gg && a[5:3] == 3'b000))) ? wr_n : 1'b1;
   assign ctl_wr_n = (io_cyc && low_port && !a[0]) ? wr_n : 1'b1;

   assign io_src = io_chip ? sms_pkg::IO_SRC_IOCHIP : sms_pkg::IO_SRC_VDP;

   // memory control may share a cycle with the io chip, the peripherals never do
   a_one_periph_wr: assert property (@(posedge clk_sys) disable iff (!RESET_n)
      $onehot0({~vdp_wr_n, ~psg_wr_n, ~io_wr_n}));

endmodule

`default_nettype wire

//--- mapper/sega_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module sega_mapper (
   input  wire                          clk_sys,
   input  wire                          RESET_n,
   input  wire [sms_pkg::ADDR_W-1:0]    a,
   input  wire [sms_pkg::DATA_W-1:0]    d_wr,
   input  wire                          mreq_n,
   input  wire                          wr_n,
   input  wire                          mapper_lock,
   output logic [sms_pkg::ROM_A_W-1:0]  rom_a,
   output logic                         nvram_e,
   output logic                         nvram_ex,
   output logic                         nvram_p,
   output logic                         nvram_cme
);

   logic [sms_pkg::BANK_W-1:0] bank0;
   logic [sms_pkg::BANK_W-1:0] bank1;
   logic [sms_pkg::BANK_W-1:0] bank2;
   logic [sms_pkg::ADDR_W-1:0] last_read_addr;
   sms_pkg::map_mode_e         map_mode;
   logic                       codies_lock;   // one chance to enter codies mode
   logic                       slot_written;  // slot 1 or 2 seen, 0000 becomes a bank write

   logic mem_wr;
   logic mem_rd;
   logic ctrl_hit;
   logic cm_en;
   logic cm0_wr;
   logic cm1_wr;
   logic cm2_wr;
   logic kr_wr;

   assign mem_wr   = !mreq_n && !wr_n;
   assign mem_rd   = !mreq_n && wr_n;
   assign ctrl_hit = a[15:2] == sms_pkg::MAP_CTRL_ADDR[15:2];

   // cartridge-space writes only while backup RAM is not mapped there
   assign cm_en  = mem_wr && !nvram_e && !mapper_lock;
   assign cm0_wr = cm_en && slot_written && a == sms_pkg::CM_SLOT0_ADDR;

   // an LDIR copy reads then writes the same address, ignore those
   assign cm1_wr = cm_en && a == sms_pkg::CM_SLOT1_ADDR
                   && last_read_addr != sms_pkg::CM_SLOT1_ADDR;
   assign cm2_wr = cm_en && a == sms_pkg::CM_SLOT2_ADDR
                   && last_read_addr != sms_pkg::CM_SLOT2_ADDR;
   assign kr_wr  = cm_en && a == sms_pkg::KR_SLOT2_ADDR
                   && last_read_addr != sms_pkg::KR_SLOT2_ADDR
                   && map_mode != sms_pkg::MAP_CODIES;

   always_ff @(posedge clk_sys) begin
      if (!RESET_n) begin
         bank0          <= sms_pkg::BANK0_RST;
         bank1          <= sms_pkg::BANK1_RST;
         bank2          <= sms_pkg::BANK2_RST;
         nvram_e        <= 1'b0;
         nvram_ex       <= 1'b0;
         nvram_p        <= 1'b0;
         nvram_cme      <= 1'b0;
         map_mode       <= sms_pkg::MAP_SEGA;
         codies_lock    <= 1'b0;
         slot_written   <= 1'b0;
         last_read_addr <= '0;
      end else begin
         if (mem_rd)
            last_read_addr <= a;

         if (mem_wr && ctrl_hit) begin
            map_mode <= sms_pkg::MAP_SEGA;
            case (a[1:0])
               2'b00: begin
                  nvram_ex <= d_wr[4];   // backup RAM over work RAM
                  nvram_e  <= d_wr[3];   // backup RAM in slot 2
                  nvram_p  <= d_wr[2];
               end
               2'b01: bank0 <= d_wr;
               2'b10: bank1 <= d_wr;
               default: bank2 <= d_wr;
            endcase
         end

         if (cm0_wr) begin
            bank0 <= d_wr;
            // only a game that left slot 1 alone writes non-zero here
            if (d_wr != '0 && !codies_lock) begin
               codies_lock <= 1'b1;
               if (bank1 == sms_pkg::BANK1_RST)
                  map_mode <= sms_pkg::MAP_CODIES;
            end
         end

         if (cm1_wr) begin
            bank1        <= {1'b0, d_wr[6:0]};
            nvram_cme    <= d_wr[7];  // 8 KB RAM at a000
            slot_written <= 1'b1;
         end

         if (cm2_wr) begin
            bank2        <= d_wr;
            slot_written <= 1'b1;
         end

         if (kr_wr)
            bank2 <= d_wr;
      end
   end

   always_comb begin
      rom_a[13:0] = a[13:0];
      case (a[15:14])
         2'b00: begin
            if (a[13:10] == 4'b0000 && map_mode != sms_pkg::MAP_CODIES)
               rom_a[sms_pkg::ROM_A_W-1:14] = '0;   // vectors stay put
            else
               rom_a[sms_pkg::ROM_A_W-1:14] = bank0;
         end
         2'b01:   rom_a[sms_pkg::ROM_A_W-1:14] = bank1;
         default: rom_a[sms_pkg::ROM_A_W-1:14] = bank2;
      endcase
   end

   // bit 7 of bank1 stays clear from a slot 1 write until the next fffe write
   a_cm_bank1_msb: assert property (@(posedge clk_sys) disable iff (!RESET_n)
      (cm1_wr || !bank1[7]) && !(mem_wr && ctrl_hit && a[1:0] == 2'b10) |=> !bank1[7]);

endmodule

`default_nettype wire

//--- mapper/mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_decode (
   input  wire [sms_pkg::ADDR_W-1:0]     a,
   input  wire [sms_pkg::DATA_W-1:0]     d_wr,
   input  wire                           mreq_n,
   input  wire                           rd_n,
   input  wire                           wr_n,
   input  wire                           nvram_e,
   input  wire                           nvram_ex,
   input  wire                           nvram_p,
   input  wire                           nvram_cme,
   output logic [sms_pkg::RAM_A_W-1:0]   ram_a,
   output logic [sms_pkg::DATA_W-1:0]    ram_d,
   output logic                          ram_we,
   output logic [sms_pkg::NVRAM_A_W-1:0] nvram_a,
   output logic [sms_pkg::DATA_W-1:0]    nvram_d,
   output logic                          nvram_we,
   output logic                          rom_rd
);

   logic mem_wr;
   logic hi_slot;     // c000..ffff
   logic nv_hit;

   assign mem_wr  = !mreq_n && !wr_n;
   assign hi_slot = a[15:14] == 2'b11;

   assign nv_hit = (a[15:14] == 2'b10 && nvram_e)
                 || (hi_slot && nvram_ex)
                 || (a[15:13] == 3'b101 && nvram_cme);

   assign ram_we   = mem_wr && hi_slot;
   assign nvram_we = mem_wr && nv_hit;
   assign rom_rd   = !mreq_n && !rd_n && !hi_slot;

   assign ram_a   = a[sms_pkg::RAM_A_W-1:0];   // 8 KB mirrored over c000..ffff
   assign ram_d   = d_wr;
   assign nvram_a = {nvram_p & ~a[14], a[13:0]};  // c000 always sees page 0
   assign nvram_d = d_wr;

   // sampled at the close of each memory cycle
   a_rom_ram_excl: assert property (@(posedge mreq_n) !(rom_rd && ram_we));

endmodule

`default_nettype wire

//--- logic/cpu_data_path.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_data_path (
   input  wire                         clk_sys,
   input  wire                         RESET_n,
   input  wire [sms_pkg::ADDR_W-1:0]   a,
   input  wire                         iorq_n,
   input  wire                         wr_n,
   input  wire                         bios_en,
   input  wire                         gg,
   input  wire                         ctl_wr_n,
   input  wire sms_pkg::io_src_e       io_src,
   input  wire                         nvram_e,
   input  wire                         nvram_ex,
   input  wire                         nvram_cme,
   input  wire [sms_pkg::DATA_W-1:0]   vdp_q,
   input  wire [sms_pkg::DATA_W-1:0]   io_q,
   input  wire [sms_pkg::DATA_W-1:0]   ram_q,
   input  wire [sms_pkg::DATA_W-1:0]   nvram_q,
   input  wire [sms_pkg::DATA_W-1:0]   rom_q,
   input  wire [sms_pkg::DATA_W-1:0]   boot_q,
   output logic [sms_pkg::DATA_W-1:0]  d_rd
);

   logic boot_on;   // boot ROM mapped at 0000..3fff

   // any write to the memory control port hands over to the cartridge
   always_ff @(posedge clk_sys) begin
      if (!RESET_n)
         boot_on <= bios_en;
      else if (!ctl_wr_n)
         boot_on <= 1'b0;
   end

   always_comb begin
      if (!iorq_n) begin
         if (io_src == sms_pkg::IO_SRC_IOCHIP)
            d_rd = {boot_on ? gg : io_q[7], io_q[6:0]};  // boot code reads console type
         else
            d_rd = vdp_q;
      end else if (a[15:14] == 2'b11) begin
         d_rd = nvram_ex ? nvram_q : ram_q;
      end else if (a[15:13] == 3'b101 && nvram_cme) begin
         d_rd = nvram_q;
      end else if (a[15:14] == 2'b10 && nvram_e) begin
         d_rd = nvram_q;
      end else if (a[15:14] == 2'b00 && boot_on) begin
         d_rd = boot_q;
      end else begin
         d_rd = rom_q;
      end
   end

   // the decoder only raises ctl_wr_n on an io write cycle
   a_ctl_is_io_wr: assert property (@(posedge clk_sys) disable iff (!RESET_n)
      !ctl_wr_n |-> !iorq_n && !wr_n);

endmodule

`default_nettype wire

//--- logic/sms_memctl.sv
`timescale 1ns/1ps
`default_nettype none

module sms_memctl (
   input  wire                           clk_sys,
   input  wire                           RESET_n,
   input  wire [sms_pkg::ADDR_W-1:0]     a,
   input  wire [sms_pkg::DATA_W-1:0]     d_wr,
   input  wire                           mreq_n,
   input  wire                           iorq_n,
   input  wire                           m1_n,
   input  wire                           rd_n,
   input  wire                           wr_n,
   input  wire                           gg,
   input  wire                           bios_en,
   input  wire                           mapper_lock,
   input  wire [sms_pkg::DATA_W-1:0]     vdp_q,
   input  wire [sms_pkg::DATA_W-1:0]     io_q,
   input  wire [sms_pkg::DATA_W-1:0]     ram_q,
   input  wire [sms_pkg::DATA_W-1:0]     nvram_q,
   input  wire [sms_pkg::DATA_W-1:0]     rom_q,
   input  wire [sms_pkg::DATA_W-1:0]     boot_q,
   output logic [sms_pkg::DATA_W-1:0]    d_rd,
   output logic [sms_pkg::ROM_A_W-1:0]   rom_a,
   output logic                          rom_rd,
   output logic [sms_pkg::RAM_A_W-1:0]   ram_a,
   output logic [sms_pkg::DATA_W-1:0]    ram_d,
   output logic                          ram_we,
   output logic [sms_pkg::NVRAM_A_W-1:0] nvram_a,
   output logic [sms_pkg::DATA_W-1:0]    nvram_d,
   output logic                          nvram_we,
   output logic                          vdp_rd_n,
   output logic                          vdp_wr_n,
   output logic                          psg_wr_n,
   output logic                          io_rd_n,
   output logic                          io_wr_n
);

   logic             ctl_wr_n;
   sms_pkg::io_src_e io_src;
   logic             nvram_e;
   logic             nvram_ex;
   logic             nvram_p;
   logic             nvram_cme;

   io_port_decode io_port_decode_inst (
      .clk_sys(clk_sys), .RESET_n(RESET_n), .a(a), .iorq_n(iorq_n),
      .m1_n(m1_n), .rd_n(rd_n), .wr_n(wr_n), .gg(gg),
      .vdp_rd_n(vdp_rd_n), .vdp_wr_n(vdp_wr_n), .psg_wr_n(psg_wr_n),
      .io_rd_n(io_rd_n), .io_wr_n(io_wr_n), .ctl_wr_n(ctl_wr_n), .io_src(io_src)
   );

   sega_mapper sega_mapper_inst (
      .clk_sys(clk_sys), .RESET_n(RESET_n), .a(a), .d_wr(d_wr),
      .mreq_n(mreq_n), .wr_n(wr_n), .mapper_lock(mapper_lock), .rom_a(rom_a),
      .nvram_e(nvram_e), .nvram_ex(nvram_ex), .nvram_p(nvram_p), .nvram_cme(nvram_cme)
   );

   mem_decode mem_decode_inst (
      .a(a), .d_wr(d_wr), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
      .nvram_e(nvram_e), .nvram_ex(nvram_ex), .nvram_p(nvram_p), .nvram_cme(nvram_cme),
      .ram_a(ram_a), .ram_d(ram_d), .ram_we(ram_we), .nvram_a(nvram_a),
      .nvram_d(nvram_d), .nvram_we(nvram_we), .rom_rd(rom_rd)
   );

   cpu_data_path cpu_data_path_inst (
      .clk_sys(clk_sys), .RESET_n(RESET_n), .a(a), .iorq_n(iorq_n), .wr_n(wr_n),
      .bios_en(bios_en), .gg(gg), .ctl_wr_n(ctl_wr_n), .io_src(io_src),
      .nvram_e(nvram_e), .nvram_ex(nvram_ex), .nvram_cme(nvram_cme),
      .vdp_q(vdp_q), .io_q(io_q), .ram_q(ram_q), .nvram_q(nvram_q),
      .rom_q(rom_q), .boot_q(boot_q), .d_rd(d_rd)
   );

endmodule

`default_nettype wire

//--- tb/sms_model.svh
`ifndef SMS_MODEL_SVH
`define SMS_MODEL_SVH

// mapper and boot state as the console hardware holds it
logic [sms_pkg::BANK_W-1:0]    m_bank0;
logic [sms_pkg::BANK_W-1:0]    m_bank1;
logic [sms_pkg::BANK_W-1:0]    m_bank2;
logic                          m_nv_e;
logic                          m_nv_ex;
logic                          m_nv_p;
logic                          m_nv_cme;
sms_pkg::map_mode_e            m_mode;
logic                          m_codies_tried;   // first non-zero slot 0 write seen
logic                          m_slot_seen;      // slot 1 or 2 written
logic [sms_pkg::ADDR_W-1:0]    m_last_rd;
logic                          m_boot;

// expected outputs for the bus state now on the pins
logic [sms_pkg::DATA_W-1:0]    exp_d_rd;
logic [sms_pkg::ROM_A_W-1:0]   exp_rom_a;
logic                          exp_rom_rd;
logic                          exp_ram_we;
logic [sms_pkg::NVRAM_A_W-1:0] exp_nv_a;
logic                          exp_nv_we;
logic                          exp_vdp_rd_n;
logic                          exp_vdp_wr_n;
logic                          exp_psg_wr_n;
logic                          exp_io_rd_n;
logic                          exp_io_wr_n;

task automatic clear_model();
   m_bank0        = 8'd0;
   m_bank1        = 8'd1;
   m_bank2        = 8'd2;
   m_nv_e         = 1'b0;
   m_nv_ex        = 1'b0;
   m_nv_p         = 1'b0;
   m_nv_cme       = 1'b0;
   m_mode         = sms_pkg::MAP_SEGA;
   m_codies_tried = 1'b0;
   m_slot_seen    = 1'b0;
   m_last_rd      = 16'h0000;
   m_boot         = bios_en;
endtask

task automatic step_model();
   logic mem_wr;
   logic cm_ok;
   mem_wr = !mreq_n && !wr_n;
   cm_ok  = mem_wr && !m_nv_e && !mapper_lock;   // cartridge writes while no backup RAM
   if (!mreq_n && wr_n)
      m_last_rd = a;
   if (mem_wr && a >= 16'hFFFC) begin
      m_mode = sms_pkg::MAP_SEGA;
      case (a[1:0])
         2'd0: begin
            m_nv_ex = d_wr[4];
            m_nv_e  = d_wr[3];
            m_nv_p  = d_wr[2];
         end
         2'd1: m_bank0 = d_wr;
         2'd2: m_bank1 = d_wr;
         default: m_bank2 = d_wr;
      endcase
   end
   if (cm_ok && a == 16'h0000 && m_slot_seen) begin
      m_bank0 = d_wr;
      if (d_wr != 8'h00 && !m_codies_tried) begin
         m_codies_tried = 1'b1;
         if (m_bank1 == 8'd1)
            m_mode = sms_pkg::MAP_CODIES;
      end
   end
   // same address as the last read means a block copy, not paging
   if (cm_ok && a == 16'h4000 && m_last_rd != a) begin
      m_bank1     = {1'b0, d_wr[6:0]};
      m_nv_cme    = d_wr[7];
      m_slot_seen = 1'b1;
   end
   if (cm_ok && a == 16'h8000 && m_last_rd != a) begin
      m_bank2     = d_wr;
      m_slot_seen = 1'b1;
   end
   if (cm_ok && a == 16'hA000 && m_last_rd != a && m_mode != sms_pkg::MAP_CODIES)
      m_bank2 = d_wr;
   if (!iorq_n && m1_n && !wr_n && a[7:6] == 2'b00 && !a[0])
      m_boot = 1'b0;   // memory control port write
endtask

task automatic predict_outputs();
   logic [7:0]                 port;
   logic                       io_cyc;
   logic                       gg_win;
   logic                       mem_wr;
   logic [sms_pkg::BANK_W-1:0] page;
   port   = a[7:0];
   io_cyc = !iorq_n && m1_n;
   gg_win = gg && port <= 8'h06;
   mem_wr = !mreq_n && !wr_n;
   if (a < 16'h0400 && m_mode != sms_pkg::MAP_CODIES)
      page = 8'd0;
   else if (a < 16'h4000)
      page = m_bank0;
   else if (a < 16'h8000)
      page = m_bank1;
   else
      page = m_bank2;
   exp_rom_a    = {page, a[13:0]};
   exp_rom_rd   = !mreq_n && !rd_n && a < 16'hC000;
   exp_ram_we   = mem_wr && a >= 16'hC000;
   exp_nv_we    = mem_wr && ((a >= 16'h8000 && a < 16'hC000 && m_nv_e)
                  || (a >= 16'hC000 && m_nv_ex)
                  || (a >= 16'hA000 && a < 16'hC000 && m_nv_cme));
   exp_nv_a     = {m_nv_p && !a[14], a[13:0]};
   exp_vdp_rd_n = !(io_cyc && port >= 8'h40 && port < 8'hC0 && !rd_n);
   exp_vdp_wr_n = !(io_cyc && port >= 8'h80 && port < 8'hC0 && !wr_n);
   exp_psg_wr_n = !(io_cyc && port >= 8'h40 && port < 8'h80 && !wr_n);
   exp_io_rd_n  = !(io_cyc && (port >= 8'hC0 || gg_win) && !rd_n);
   exp_io_wr_n  = !(io_cyc && ((port < 8'h40 && port[0]) || (gg && port < 8'h08)) && !wr_n);
   if (!iorq_n)
      exp_d_rd = (port >= 8'hC0 || gg_win) ? {m_boot ? gg : io_q[7], io_q[6:0]} : vdp_q;
   else if (a >= 16'hC000)
      exp_d_rd = m_nv_ex ? nvram_q : ram_q;
   else if (a >= 16'hA000 && m_nv_cme)
      exp_d_rd = nvram_q;
   else if (a >= 16'h8000 && m_nv_e)
      exp_d_rd = nvram_q;
   else if (a < 16'h4000 && m_boot)
      exp_d_rd = boot_q;
   else
      exp_d_rd = rom_q;
endtask

`endif

//--- tb/sms_memctl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sms_memctl_tb;

   localparam int BOOT_CYCLES = 500;    // reads only, boot ROM stays mapped
   localparam int BUS_CYCLES  = 3000;
   localparam int MAX_CYCLES  = 8000;   // two clocks per bus cycle plus margin

   localparam logic [1:0] MEM_RD = 2'd0;
   localparam logic [1:0] MEM_WR = 2'd1;
   localparam logic [1:0] IO_RD  = 2'd2;
   localparam logic [1:0] IO_WR  = 2'd3;

   logic                          clk_sys;
   logic                          RESET_n;
   logic [sms_pkg::ADDR_W-1:0]    a;
   logic [sms_pkg::DATA_W-1:0]    d_wr;
   logic                          mreq_n;
   logic                          iorq_n;
   logic                          m1_n;
   logic                          rd_n;
   logic                          wr_n;
   logic                          gg;
   logic                          bios_en;
   logic                          mapper_lock;
   logic [sms_pkg::DATA_W-1:0]    vdp_q;
   logic [sms_pkg::DATA_W-1:0]    io_q;
   logic [sms_pkg::DATA_W-1:0]    ram_q;
   logic [sms_pkg::DATA_W-1:0]    nvram_q;
   logic [sms_pkg::DATA_W-1:0]    rom_q;
   logic [sms_pkg::DATA_W-1:0]    boot_q;
   logic [sms_pkg::DATA_W-1:0]    d_rd;
   logic [sms_pkg::ROM_A_W-1:0]   rom_a;
   logic                          rom_rd;
   logic [sms_pkg::RAM_A_W-1:0]   ram_a;
   logic [sms_pkg::DATA_W-1:0]    ram_d;
   logic                          ram_we;
   logic [sms_pkg::NVRAM_A_W-1:0] nvram_a;
   logic [sms_pkg::DATA_W-1:0]    nvram_d;
   logic                          nvram_we;
   logic                          vdp_rd_n;
   logic                          vdp_wr_n;
   logic                          psg_wr_n;
   logic                          io_rd_n;
   logic                          io_wr_n;

   integer seed;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;

   `include "sms_model.svh"

   sms_memctl sms_memctl_inst (.*);

   initial begin
      clk_sys = 1'b0;
      forever #2 clk_sys = ~clk_sys;
   end

   // model registers follow the DUT edges
   always @(posedge clk_sys) begin
      if (!RESET_n)
         clear_model();
      else
         step_model();
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_sys);
         cycles++;
      end
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("Test failures found");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      checks++;
      assert (act_v === exp_v)
      else begin
         errors++;
         $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic compare_outputs();
      predict_outputs();
      check_val("d_rd", 32'(exp_d_rd), 32'(d_rd));
      check_val("rom_a", 32'(exp_rom_a), 32'(rom_a));
      check_val("rom_rd", 32'(exp_rom_rd), 32'(rom_rd));
      check_val("ram_a", 32'(a[12:0]), 32'(ram_a));
      check_val("ram_d", 32'(d_wr), 32'(ram_d));
      check_val("ram_we", 32'(exp_ram_we), 32'(ram_we));
      check_val("nvram_a", 32'(exp_nv_a), 32'(nvram_a));
      check_val("nvram_d", 32'(d_wr), 32'(nvram_d));
      check_val("nvram_we", 32'(exp_nv_we), 32'(nvram_we));
      check_val("vdp_rd_n", 32'(exp_vdp_rd_n), 32'(vdp_rd_n));
      check_val("vdp_wr_n", 32'(exp_vdp_wr_n), 32'(vdp_wr_n));
      check_val("psg_wr_n", 32'(exp_psg_wr_n), 32'(psg_wr_n));
      check_val("io_rd_n", 32'(exp_io_rd_n), 32'(io_rd_n));
      check_val("io_wr_n", 32'(exp_io_wr_n), 32'(io_wr_n));
   endtask

   task automatic shuffle_read_data();
      logic [31:0] r0;
      logic [31:0] r1;
      r0 = $random(seed);
      r1 = $random(seed);
      vdp_q   <= r0[7:0];
      io_q    <= r0[15:8];
      ram_q   <= r0[23:16];
      nvram_q <= r0[31:24];
      rom_q   <= r1[7:0];
      boot_q  <= r1[15:8];
   endtask

   // one clock of bus cycle, then one idle clock
   task automatic run_cycle(input logic [1:0] kind, input logic [15:0] addr,
                            input logic [7:0] data, input logic lock);
      logic [31:0] pick;
      pick = $random(seed);
      @(posedge clk_sys);
      a           <= addr;
      d_wr        <= data;
      mreq_n      <= kind[1];
      iorq_n      <= !kind[1];
      m1_n        <= !kind[1] || pick[2:0] != 3'd0;   // some io cycles are interrupt acks
      rd_n        <= kind[0];
      wr_n        <= !kind[0];
      gg          <= pick[3];
      mapper_lock <= lock;
      shuffle_read_data();
      @(negedge clk_sys);
      compare_outputs();
      @(posedge clk_sys);
      a      <= pick[31:16];
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      m1_n   <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      shuffle_read_data();
      @(negedge clk_sys);
      compare_outputs();
   endtask

   function automatic logic [15:0] slot_addr(input logic [1:0] sel);
      case (sel)
         2'd0: slot_addr = sms_pkg::CM_SLOT0_ADDR;
         2'd1: slot_addr = sms_pkg::CM_SLOT1_ADDR;
         2'd2: slot_addr = sms_pkg::CM_SLOT2_ADDR;
         default: slot_addr = sms_pkg::KR_SLOT2_ADDR;
      endcase
   endfunction

   initial begin
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] sel;
      logic        lock;
      seed        = 32'hcb50_0eaf;
      RESET_n     = 1'b0;
      a           = '0;
      d_wr        = '0;
      mreq_n      = 1'b1;
      iorq_n      = 1'b1;
      m1_n        = 1'b1;
      rd_n        = 1'b1;
      wr_n        = 1'b1;
      gg          = 1'b0;
      bios_en     = 1'b1;
      mapper_lock = 1'b0;
      vdp_q       = '0;
      io_q        = '0;
      ram_q       = '0;
      nvram_q     = '0;
      rom_q       = '0;
      boot_q      = '0;
      repeat (16) @(posedge clk_sys);
      RESET_n <= 1'b1;

      for (int i = 0; i < BOOT_CYCLES; i++) begin
         addr = $random(seed);
         data = $random(seed);
         sel  = $random(seed);
         run_cycle(sel[3] ? IO_RD : MEM_RD, addr[15:0], data[7:0], sel[4]);
      end

      // slot 2 write arms slot 0, a non-zero slot 0 write with bank1 at 1 enters codies
      run_cycle(MEM_RD, 16'h0100, 8'h00, 1'b0);
      run_cycle(MEM_WR, sms_pkg::CM_SLOT2_ADDR, 8'h05, 1'b0);
      run_cycle(MEM_WR, sms_pkg::CM_SLOT0_ADDR, 8'h03, 1'b0);
      run_cycle(MEM_RD, 16'h0123, 8'h00, 1'b0);
      assert (sms_memctl_inst.sega_mapper_inst.map_mode == sms_pkg::MAP_CODIES
              && m_mode == sms_pkg::MAP_CODIES)
      else begin
         errors++;
         $display("the codemasters detection sequence did not reach codies mode");
      end

      for (int i = BOOT_CYCLES; i < BUS_CYCLES; i++) begin
         addr = $random(seed);
         data = $random(seed);
         sel  = $random(seed);
         lock = sel[6:4] == 3'd0;
         case (sel[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: run_cycle(MEM_RD, addr[15:0], data[7:0], lock);
            4'd4: begin
               // read then write the same slot as an LDIR copy does
               run_cycle(MEM_RD, slot_addr(addr[1:0]), data[7:0], lock);
               run_cycle(MEM_WR, slot_addr(addr[1:0]), data[7:0] & 8'h87, lock);
            end
            4'd5, 4'd6: run_cycle(MEM_WR, {14'h3FFF, addr[1:0]}, data[7:0], lock);
            4'd7, 4'd8, 4'd9: run_cycle(MEM_WR, slot_addr(addr[1:0]), data[7:0] & 8'h87, lock);
            4'd10, 4'd11: run_cycle(MEM_WR, addr[15:0], data[7:0], lock);
            4'd12, 4'd13: run_cycle(IO_RD, addr[15:0], data[7:0], lock);
            default: run_cycle(IO_WR, addr[15:0], data[7:0], lock);
         endcase
      end

      @(posedge clk_sys);
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
common/sms_pkg.sv
logic/io_port_decode.sv
mapper/sega_mapper.sv
mapper/mem_decode.sv
logic/cpu_data_path.sv
logic/sms_memctl.sv
tb/sms_memctl_tb.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= sms_memctl_tb
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
